//--- Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module board_core_tb \
		-f vlog.f -o board_core_sim
	./obj_dir/board_core_sim 2>&1 | tee $(LOG)
	grep -q "test passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module board_core_tb -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

//--- design/board_core.sv
// Loopback board core

`resetall
`timescale 1ns/1ns
`default_nettype none

`include "loopback_params.svh"

module board_core (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,

    input  wire logic [7:0]           sw,
    output logic [7:0]                led,

    input  wire logic                 uart_rxd,
    output logic                      uart_txd,

    input  wire loopback_pkg::byte_t  sfp0_gmii_rxd,
    input  wire logic                 sfp0_gmii_rx_dv,
    input  wire logic                 sfp0_gmii_rx_er,
    output loopback_pkg::byte_t       sfp0_gmii_txd,
    output logic                      sfp0_gmii_tx_en,

    input  wire loopback_pkg::byte_t  sfp1_gmii_rxd,
    input  wire logic                 sfp1_gmii_rx_dv,
    input  wire logic                 sfp1_gmii_rx_er,
    output loopback_pkg::byte_t       sfp1_gmii_txd,
    output logic                      sfp1_gmii_tx_en
);

loopback_pkg::byte_t uart_rx_data;
logic uart_rx_valid;

logic sfp0_rd_valid;
logic sfp0_rd_en;
loopback_pkg::frame_word_t sfp0_rd_data;

logic sfp1_rd_valid;
logic sfp1_rd_en;
loopback_pkg::frame_word_t sfp1_rd_data;

assign led = sw;

// UART echo, a byte arriving while the transmitter is busy is dropped
uart_rx uart_rx_inst (
    .clk_125mhz  (clk_125mhz),
    .rst_n       (rst_n),
    .rxd         (uart_rxd),
    .rx_data     (uart_rx_data),
    .rx_valid    (uart_rx_valid),
    .frame_error ()
);

uart_tx uart_tx_inst (
    .clk_125mhz (clk_125mhz),
    .rst_n      (rst_n),
    .tx_data    (uart_rx_data),
    .tx_valid   (uart_rx_valid),
    .tx_ready   (),
    .txd        (uart_txd)
);

// SFP0 loopback lane
frame_fifo #(
    .DEPTH(`FRAME_FIFO_DEPTH)
) sfp0_fifo_inst (
    .clk_125mhz (clk_125mhz),
    .rst_n      (rst_n),
    .rx_data    (sfp0_gmii_rxd),
    .rx_dv      (sfp0_gmii_rx_dv),
    .rx_er      (sfp0_gmii_rx_er),
    .rd_en      (sfp0_rd_en),
    .rd_valid   (sfp0_rd_valid),
    .rd_data    (sfp0_rd_data)
);

gmii_tx_frame sfp0_tx_inst (
    .clk_125mhz (clk_125mhz),
    .rst_n      (rst_n),
    .rd_valid   (sfp0_rd_valid),
    .rd_data    (sfp0_rd_data),
    .rd_en      (sfp0_rd_en),
    .gmii_txd   (sfp0_gmii_txd),
    .gmii_tx_en (sfp0_gmii_tx_en)
);

// SFP1 loopback lane
frame_fifo #(
    .DEPTH(`FRAME_FIFO_DEPTH)
) sfp1_fifo_inst (
    .clk_125mhz (clk_125mhz),
    .rst_n      (rst_n),
    .rx_data    (sfp1_gmii_rxd),
    .rx_dv      (sfp1_gmii_rx_dv),
    .rx_er      (sfp1_gmii_rx_er),
    .rd_en      (sfp1_rd_en),
    .rd_valid   (sfp1_rd_valid),
    .rd_data    (sfp1_rd_data)
);

gmii_tx_frame sfp1_tx_inst (
    .clk_125mhz (clk_125mhz),
    .rst_n      (rst_n),
    .rd_valid   (sfp1_rd_valid),
    .rd_data    (sfp1_rd_data),
    .rd_en      (sfp1_rd_en),
    .gmii_txd   (sfp1_gmii_txd),
    .gmii_tx_en (sfp1_gmii_tx_en)
);

endmodule

`resetall

//--- design/frame_fifo.sv
// Store-and-forward frame FIFO

`resetall
`timescale 1ns/1ns
`default_nettype none

`include "loopback_params.svh"

module frame_fifo #(
    parameter int DEPTH = `FRAME_FIFO_DEPTH
) (
    input  wire logic                      clk_125mhz,
    input  wire logic                      rst_n,
    input  wire loopback_pkg::byte_t       rx_data,
    input  wire logic                      rx_dv,
    input  wire logic                      rx_er,
    input  wire logic                      rd_en,
    output logic                           rd_valid,
    output loopback_pkg::frame_word_t      rd_data
);

localparam int ADDR_W = $clog2(DEPTH);

loopback_pkg::frame_word_t mem [DEPTH];

// Extra MSB tells full from empty
logic [ADDR_W:0] wr_ptr;
logic [ADDR_W:0] wr_ptr_commit;
logic [ADDR_W:0] rd_ptr;

// Byte held back one cycle until its last flag is known
logic hold_valid;
loopback_pkg::byte_t hold_data;

logic bad;
logic full;
logic frame_end;
logic wr_en;

assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
              (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
assign frame_end = hold_valid && !rx_dv;

// Once a frame is bad nothing more of it is stored
assign wr_en = hold_valid && !full && !bad;

// Only committed words are visible to the reader
assign rd_valid = (rd_ptr != wr_ptr_commit);
assign rd_data = mem[rd_ptr[ADDR_W-1:0]];

always_ff @(posedge clk_125mhz) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        wr_ptr_commit <= '0;
        rd_ptr <= '0;
        hold_valid <= 1'b0;
        bad <= 1'b0;
    end else begin
        hold_valid <= rx_dv;

        if (frame_end) begin
            bad <= 1'b0;
            if (wr_en) begin
                // Last byte stored too, so the whole frame is good
                wr_ptr <= wr_ptr + 1'b1;
                wr_ptr_commit <= wr_ptr + 1'b1;
            end else begin
                wr_ptr <= wr_ptr_commit;
            end
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Sticky until the end of the frame
            if ((rx_dv && rx_er) || (hold_valid && full)) begin
                bad <= 1'b1;
            end
        end

        if (rd_en && rd_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

always_ff @(posedge clk_125mhz) begin
    if (rx_dv) begin
        hold_data <= rx_data;
    end
end

always_ff @(posedge clk_125mhz) begin
    if (wr_en) begin
        mem[wr_ptr[ADDR_W-1:0]] <= loopback_pkg::frame_word_t'{data: hold_data, last: !rx_dv};
    end
end

endmodule

`resetall

//--- design/gmii_tx_frame.sv
// GMII frame transmitter

`resetall
`timescale 1ns/1ns
`default_nettype none

`include "loopback_params.svh"

module gmii_tx_frame (
    input  wire logic                       clk_125mhz,
    input  wire logic                       rst_n,
    input  wire logic                       rd_valid,
    input  wire loopback_pkg::frame_word_t  rd_data,
    output logic                            rd_en,
    output loopback_pkg::byte_t             gmii_txd,
    output logic                            gmii_tx_en
);

localparam int GAP_W = $clog2(`IFG_CYCLES);
localparam logic [GAP_W-1:0] GAP_END = GAP_W'(`IFG_CYCLES - 1);

loopback_pkg::gmii_tx_state_t state;
logic [GAP_W-1:0] gap_cnt;

// Whole frames only, so rd_valid stays high until the last word
assign rd_en = rd_valid && (state != loopback_pkg::TX_GAP);

always_ff @(posedge clk_125mhz) begin
    if (!rst_n) begin
        state <= loopback_pkg::TX_IDLE;
        gap_cnt <= '0;
        gmii_tx_en <= 1'b0;
    end else begin
        gmii_tx_en <= rd_en;

        case (state)
            loopback_pkg::TX_IDLE,
            loopback_pkg::TX_SEND: begin
                gap_cnt <= '0;
                if (rd_en) begin
                    state <= rd_data.last ? loopback_pkg::TX_GAP : loopback_pkg::TX_SEND;
                end
            end
            loopback_pkg::TX_GAP: begin
                // tx_en drops on the first gap cycle
                if (gap_cnt == GAP_END) begin
                    state <= loopback_pkg::TX_IDLE;
                end else begin
                    gap_cnt <= gap_cnt + 1'b1;
                end
            end
            default: state <= loopback_pkg::TX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_125mhz) begin
    if (rd_en) begin
        gmii_txd <= rd_data.data;
    end
end

endmodule

`resetall

//--- design/loopback_params.svh
// Loopback design constants

`ifndef LOOPBACK_PARAMS_SVH
`define LOOPBACK_PARAMS_SVH

// Core clock and UART line rate
`define CLK_FREQ_HZ 125000000
`define UART_BAUD 115200

// Clock cycles per UART bit, 1085 at 125 MHz
`define UART_PRESCALE (`CLK_FREQ_HZ / `UART_BAUD)

// Frame FIFO size per SFP port, in bytes
`define FRAME_FIFO_DEPTH 256
`define FIFO_ADDR_W 8

// Idle cycles between transmitted frames
`define IFG_CYCLES 12

`endif

//--- design/loopback_pkg.sv
// Loopback shared types

package loopback_pkg;

    typedef logic [7:0] byte_t;

    // One FIFO entry, last marks the final byte of a frame
    typedef struct packed {
        byte_t data;
        logic  last;
    } frame_word_t;

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SEND,
        TX_GAP
    } gmii_tx_state_t;

endpackage

//--- design/uart_rx.sv
// UART receiver

`resetall
`timescale 1ns/1ns
`default_nettype none

`include "loopback_params.svh"

module uart_rx (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,
    input  wire logic                 rxd,
    output loopback_pkg::byte_t       rx_data,
    output logic                      rx_valid,
    output logic                      frame_error
);

localparam int PRESCALE = `UART_PRESCALE;
localparam int CNT_W = $clog2(PRESCALE);
localparam logic [CNT_W-1:0] HALF_END = CNT_W'(PRESCALE / 2 - 1);
localparam logic [CNT_W-1:0] BIT_END = CNT_W'(PRESCALE - 1);

logic rxd_meta;
logic rxd_sync;
logic rxd_last;
loopback_pkg::uart_state_t state;
logic [CNT_W-1:0] cnt;
logic [2:0] bit_cnt;
loopback_pkg::byte_t shift;

assign rx_data = shift;

always_ff @(posedge clk_125mhz) begin
    if (!rst_n) begin
        rxd_meta <= 1'b1;
        rxd_sync <= 1'b1;
        rxd_last <= 1'b1;
        state <= loopback_pkg::UART_IDLE;
        cnt <= '0;
        bit_cnt <= '0;
        rx_valid <= 1'b0;
        frame_error <= 1'b0;
    end else begin
        // Two-flop synchronizer plus one more for edge detection
        rxd_meta <= rxd;
        rxd_sync <= rxd_meta;
        rxd_last <= rxd_sync;
        rx_valid <= 1'b0;
        frame_error <= 1'b0;

        case (state)
            loopback_pkg::UART_IDLE: begin
                cnt <= '0;
                bit_cnt <= '0;
                if (rxd_last && !rxd_sync) begin
                    state <= loopback_pkg::UART_START;
                end
            end
            loopback_pkg::UART_START: begin
                if (cnt == HALF_END) begin
                    cnt <= '0;
                    // A line that is high again at mid start bit was a glitch
                    state <= rxd_sync ? loopback_pkg::UART_IDLE : loopback_pkg::UART_DATA;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            loopback_pkg::UART_DATA: begin
                if (cnt == BIT_END) begin
                    cnt <= '0;
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        state <= loopback_pkg::UART_STOP;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            loopback_pkg::UART_STOP: begin
                if (cnt == BIT_END) begin
                    state <= loopback_pkg::UART_IDLE;
                    rx_valid <= rxd_sync;
                    frame_error <= !rxd_sync;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
            default: state <= loopback_pkg::UART_IDLE;
        endcase
    end
end

// Data bits arrive LSB first
always_ff @(posedge clk_125mhz) begin
    if (state == loopback_pkg::UART_DATA && cnt == BIT_END) begin
        shift <= {rxd_sync, shift[7:1]};
    end
end

endmodule

`resetall

//--- design/uart_tx.sv
// UART transmitter

`resetall
`timescale 1ns/1ns
`default_nettype none

`include "loopback_params.svh"

module uart_tx (
    input  wire logic                 clk_125mhz,
    input  wire logic                 rst_n,
    input  wire loopback_pkg::byte_t  tx_data,
    input  wire logic                 tx_valid,
    output logic                      tx_ready,
    output logic                      txd
);

localparam int PRESCALE = `UART_PRESCALE;
localparam int CNT_W = $clog2(PRESCALE);
localparam logic [CNT_W-1:0] BIT_END = CNT_W'(PRESCALE - 1);

loopback_pkg::uart_state_t state;
logic [CNT_W-1:0] cnt;
logic [2:0] bit_cnt;
loopback_pkg::byte_t shift;

assign tx_ready = (state == loopback_pkg::UART_IDLE);

always_ff @(posedge clk_125mhz) begin
    if (!rst_n) begin
        state <= loopback_pkg::UART_IDLE;
        cnt <= '0;
        bit_cnt <= '0;
        txd <= 1'b1;
    end else begin
        if (state == loopback_pkg::UART_IDLE) begin
            cnt <= '0;
            bit_cnt <= '0;
            if (tx_valid) begin
                txd <= 1'b0;
                state <= loopback_pkg::UART_START;
            end
        end else if (cnt != BIT_END) begin
            cnt <= cnt + 1'b1;
        end else begin
            // End of the current bit period
            cnt <= '0;
            case (state)
                loopback_pkg::UART_START: begin
                    txd <= shift[0];
                    state <= loopback_pkg::UART_DATA;
                end
                loopback_pkg::UART_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        txd <= 1'b1;
                        state <= loopback_pkg::UART_STOP;
                    end else begin
                        txd <= shift[1];
                    end
                end
                default: state <= loopback_pkg::UART_IDLE;
            endcase
        end
    end
end

// Load on acceptance, shift right after each data bit
always_ff @(posedge clk_125mhz) begin
    if (tx_valid && tx_ready) begin
        shift <= tx_data;
    end else if (state == loopback_pkg::UART_DATA && cnt == BIT_END) begin
        shift <= shift >> 1;
    end
end

endmodule

`resetall

//--- verif/board_core_properties.sv
// Loopback port assertions

`timescale 1ns/1ns

`include "loopback_params.svh"

module board_core_properties (
    input wire logic clk_125mhz,
    input wire logic rst_n,
    input wire logic uart_txd,
    input wire logic sfp0_gmii_tx_en,
    input wire logic sfp1_gmii_tx_en
);

// Idle cycles since tx_en was last high, saturating
logic [7:0] sfp0_idle;
logic [7:0] sfp1_idle;

always_ff @(posedge clk_125mhz) begin
    if (!rst_n || sfp0_gmii_tx_en) begin
        sfp0_idle <= rst_n ? 8'h00 : 8'hff;
    end else if (sfp0_idle != 8'hff) begin
        sfp0_idle <= sfp0_idle + 1'b1;
    end
end

always_ff @(posedge clk_125mhz) begin
    if (!rst_n || sfp1_gmii_tx_en) begin
        sfp1_idle <= rst_n ? 8'h00 : 8'hff;
    end else if (sfp1_idle != 8'hff) begin
        sfp1_idle <= sfp1_idle + 1'b1;
    end
end

uart_idle_in_reset: assert property (@(posedge clk_125mhz) !rst_n |=> uart_txd)
    else $error("uart_txd is not high during reset");

tx_en_low_in_reset: assert property (@(posedge clk_125mhz)
    !rst_n |=> !sfp0_gmii_tx_en && !sfp1_gmii_tx_en)
    else $error("SFP tx_en is high during reset");

sfp0_gap: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
    $rose(sfp0_gmii_tx_en) |-> sfp0_idle >= `IFG_CYCLES)
    else $error("sfp0 inter-frame gap too short");

sfp1_gap: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
    $rose(sfp1_gmii_tx_en) |-> sfp1_idle >= `IFG_CYCLES)
    else $error("sfp1 inter-frame gap too short");

endmodule

//--- verif/board_core_tb.sv
// Loopback board testbench

`timescale 1ns/1ns

`include "loopback_params.svh"

module board_core_tb;

localparam int N_UART = 16;
localparam int N_FRAMES = 12;
localparam int N_SW = 20;
// UART echo dominates, about 22 bit times per byte, frames run alongside
localparam int TIMEOUT_CYCLES = N_UART * 22 * `UART_PRESCALE + 20000;

logic clk_125mhz;
logic rst_n;
logic [7:0] sw;
logic [7:0] led;
logic uart_rxd;
logic uart_txd;
loopback_pkg::byte_t sfp0_gmii_rxd;
logic sfp0_gmii_rx_dv;
logic sfp0_gmii_rx_er;
loopback_pkg::byte_t sfp0_gmii_txd;
logic sfp0_gmii_tx_en;
loopback_pkg::byte_t sfp1_gmii_rxd;
logic sfp1_gmii_rx_dv;
logic sfp1_gmii_rx_er;
loopback_pkg::byte_t sfp1_gmii_txd;
logic sfp1_gmii_tx_en;

integer seed;
int cycle_cnt;
logic [7:0] uart_bytes [N_UART];

// Reference model, expected bytes and frame lengths
logic [7:0] uart_exp [$];
logic [7:0] lane_exp [2][$];
int lane_len [2][$];

board_core i_dut (
    .clk_125mhz      (clk_125mhz),
    .rst_n           (rst_n),
    .sw              (sw),
    .led             (led),
    .uart_rxd        (uart_rxd),
    .uart_txd        (uart_txd),
    .sfp0_gmii_rxd   (sfp0_gmii_rxd),
    .sfp0_gmii_rx_dv (sfp0_gmii_rx_dv),
    .sfp0_gmii_rx_er (sfp0_gmii_rx_er),
    .sfp0_gmii_txd   (sfp0_gmii_txd),
    .sfp0_gmii_tx_en (sfp0_gmii_tx_en),
    .sfp1_gmii_rxd   (sfp1_gmii_rxd),
    .sfp1_gmii_rx_dv (sfp1_gmii_rx_dv),
    .sfp1_gmii_rx_er (sfp1_gmii_rx_er),
    .sfp1_gmii_txd   (sfp1_gmii_txd),
    .sfp1_gmii_tx_en (sfp1_gmii_tx_en)
);

bind board_core board_core_properties i_props (
    .clk_125mhz      (clk_125mhz),
    .rst_n           (rst_n),
    .uart_txd        (uart_txd),
    .sfp0_gmii_tx_en (sfp0_gmii_tx_en),
    .sfp1_gmii_tx_en (sfp1_gmii_tx_en)
);

initial begin
    clk_125mhz = 1'b0;
    forever #4 clk_125mhz = ~clk_125mhz;
end

task automatic abort_run();
    $display("test failed");
    $fatal(1, "Simulation stopped on the first error");
endtask

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
        $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        abort_run();
    end
endtask

function automatic int rand_range(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
endfunction

task automatic drive_lane(input int lane, input logic dv, input logic er, input logic [7:0] d);
    if (lane == 0) begin
        sfp0_gmii_rx_dv <= dv;
        sfp0_gmii_rx_er <= er;
        sfp0_gmii_rxd <= d;
    end else begin
        sfp1_gmii_rx_dv <= dv;
        sfp1_gmii_rx_er <= er;
        sfp1_gmii_rxd <= d;
    end
endtask

// err_pos below zero means a clean frame
task automatic send_frame(input int lane, input int len, input int err_pos);
    logic [7:0] value;
    logic keep;
    keep = (err_pos < 0) && (len <= `FRAME_FIFO_DEPTH);
    for (int i = 0; i < len; i++) begin
        value = 8'($random(seed));
        drive_lane(lane, 1'b1, i == err_pos, value);
        if (keep) begin
            lane_exp[lane].push_back(value);
        end
        @(posedge clk_125mhz);
    end
    if (keep) begin
        lane_len[lane].push_back(len);
    end
    drive_lane(lane, 1'b0, 1'b0, 8'h00);
    repeat (rand_range(16, 24)) @(posedge clk_125mhz);
endtask

task automatic run_lane(input int lane);
    int len;
    int err_pos;
    for (int f = 0; f < N_FRAMES; f++) begin
        len = rand_range(1, 100);
        // Every fourth frame carries rx_er on one random byte
        err_pos = (f % 4 == 2) ? rand_range(0, len - 1) : -1;
        send_frame(lane, len, err_pos);
    end
    // Too big for the FIFO, then a good frame right behind it
    send_frame(lane, 300, -1);
    send_frame(lane, rand_range(1, 100), -1);
endtask

task automatic send_uart_byte(input logic [7:0] value);
    logic [9:0] bits;
    bits = {1'b1, value, 1'b0};
    for (int i = 0; i < 10; i++) begin
        uart_rxd <= bits[0];
        bits = bits >> 1;
        repeat (`UART_PRESCALE) @(posedge clk_125mhz);
    end
    // One full character of idle line
    repeat (10 * `UART_PRESCALE) @(posedge clk_125mhz);
endtask

task automatic watch_uart();
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    forever begin
        @(posedge clk_125mhz);
        if (uart_txd === 1'b0) begin
            repeat (`UART_PRESCALE / 2) @(posedge clk_125mhz);
            check_value("uart_txd start bit", 32'(uart_txd), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (`UART_PRESCALE) @(posedge clk_125mhz);
                rx_byte = {uart_txd, rx_byte[7:1]};
            end
            repeat (`UART_PRESCALE) @(posedge clk_125mhz);
            check_value("uart_txd stop bit", 32'(uart_txd), 32'd1);
            if (uart_exp.size() == 0) begin
                $display("UART sent a byte that was never received");
                abort_run();
            end
            exp_byte = uart_exp.pop_front();
            check_value("uart_txd byte", 32'(rx_byte), 32'(exp_byte));
        end
    end
endtask

task automatic watch_lane(input int lane);
    int run_len;
    int gap_len;
    logic en;
    logic [7:0] data;
    run_len = 0;
    gap_len = `IFG_CYCLES;
    forever begin
        @(posedge clk_125mhz);
        en = (lane != 0) ? sfp1_gmii_tx_en : sfp0_gmii_tx_en;
        data = (lane != 0) ? sfp1_gmii_txd : sfp0_gmii_txd;
        if (en === 1'b1) begin
            if (run_len == 0 && gap_len < `IFG_CYCLES) begin
                $display("Only %0d idle cycles between frames on sfp%0d", gap_len, lane);
                abort_run();
            end
            if (lane_exp[lane].size() == 0) begin
                $display("Frame byte on sfp%0d that was never expected", lane);
                abort_run();
            end
            check_value($sformatf("sfp%0d_gmii_txd", lane), 32'(data),
                        32'(lane_exp[lane].pop_front()));
            run_len++;
            gap_len = 0;
        end else begin
            if (run_len != 0) begin
                if (lane_len[lane].size() == 0) begin
                    $display("Frame ended on sfp%0d with no length expected", lane);
                    abort_run();
                end
                check_value($sformatf("sfp%0d frame length", lane), 32'(run_len),
                            32'(lane_len[lane].pop_front()));
                run_len = 0;
            end
            gap_len++;
        end
    end
endtask

initial begin
    cycle_cnt = 0;
    forever begin
        @(posedge clk_125mhz);
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with traffic still pending", cycle_cnt);
            abort_run();
        end
    end
end

initial begin
    wait (rst_n === 1'b1);
    fork
        watch_uart();
        watch_lane(0);
        watch_lane(1);
    join
end

initial begin
    logic [7:0] sw_value;
    seed = 32'h649f;
    rst_n = 1'b0;
    sw = 8'h00;
    uart_rxd = 1'b1;
    sfp0_gmii_rxd = 8'h00;
    sfp0_gmii_rx_dv = 1'b0;
    sfp0_gmii_rx_er = 1'b0;
    sfp1_gmii_rxd = 8'h00;
    sfp1_gmii_rx_dv = 1'b0;
    sfp1_gmii_rx_er = 1'b0;
    for (int i = 0; i < N_UART; i++) begin
        uart_bytes[i] = 8'($random(seed));
    end
    repeat (8) @(posedge clk_125mhz);
    rst_n <= 1'b1;
    fork
        for (int i = 0; i < N_UART; i++) begin
            uart_exp.push_back(uart_bytes[i]);
            send_uart_byte(uart_bytes[i]);
        end
        begin
            for (int i = 0; i < N_SW; i++) begin
                sw_value = 8'($random(seed));
                sw <= sw_value;
                @(posedge clk_125mhz);
                check_value("led", 32'(led), 32'(sw_value));
            end
            run_lane(0);
            run_lane(1);
        end
    join
    while (uart_exp.size() != 0 || lane_len[0].size() != 0 || lane_len[1].size() != 0) begin
        @(posedge clk_125mhz);
    end
    repeat (4 * `IFG_CYCLES) @(posedge clk_125mhz);
    if (lane_exp[0].size() == 0 && lane_exp[1].size() == 0 &&
        sfp0_gmii_tx_en === 1'b0 && sfp1_gmii_tx_en === 1'b0) begin
        $display("test passed");
        $finish;
    end else begin
        $display("Frame bytes left over or tx_en still high at the end of the run");
        abort_run();
    end
end

endmodule

//--- vlog.f
+incdir+design
design/loopback_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/frame_fifo.sv
design/gmii_tx_frame.sv
design/board_core.sv
verif/board_core_properties.sv
verif/board_core_tb.sv
